// File: logic/soc_defs.svh
/*
 * Widths, slot map and device ids of the APB peripheral subsystem.
 * Slots are 4 KB each, and the last slot catches unowned addresses.
 */
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Bus widths
`define ADDR_BITSZ 16
`define DATA_BITSZ 32

`define GPIO_COUNT 8

// Address map, one device per slot
`define SLOT_SHIFT 12
`define SLOT_COUNT 4

// Interrupt source positions
`define INT_SRC_COUNT 3
`define INT_SRC_GPIO  0
`define INT_SRC_EXT0  1
`define INT_SRC_EXT1  2

// Peripheral reset hold length
`define RST_CNTR_BITSZ 4

// Device ids reported through the device table
`define DEV_ID_DEVTBL  7
`define DEV_ID_GPIO    6
`define DEV_ID_INTCTRL 3

`define RSTCTRL_OFFSET 'h100

`endif

// File: logic/soc_pkg.sv
/*
 * Types shared by the peripheral subsystem.
 * SLOT_TABLE must list one entry per slot in address order.
 */
`include "soc_defs.svh"

package soc_pkg;

	typedef logic [`ADDR_BITSZ-1:0]    addr_t;
	typedef logic [`DATA_BITSZ-1:0]    data_t;
	typedef logic [`GPIO_COUNT-1:0]    gpio_t;
	typedef logic [`INT_SRC_COUNT-1:0] irq_vec_t;

	typedef enum logic [1:0] {
		SLOT_DEVTBL  = 2'd0,
		SLOT_GPIO    = 2'd1,
		SLOT_INTCTRL = 2'd2,
		SLOT_INVALID = 2'd3
	} slot_e;

	// Master to slave, 51 bits
	typedef struct packed {
		logic  psel;
		logic  penable;
		logic  pwrite;
		addr_t paddr;
		data_t pwdata;
	} apb_req_t;

	// Slave to master, 34 bits
	typedef struct packed {
		data_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic [7:0] id;
		logic       useintr;
		data_t      mapsz;
	} dev_entry_t;

	typedef enum logic [1:0] {
		RST_HOLD,
		RST_RUN,
		RST_OFF
	} rst_state_e;

	parameter data_t SLOT_MAPSZ = data_t'(1) << `SLOT_SHIFT;

	// Id 0 marks the invalid-device slot
	parameter dev_entry_t SLOT_TABLE [`SLOT_COUNT] = '{
		'{id: 8'(`DEV_ID_DEVTBL),  useintr: 1'b0, mapsz: SLOT_MAPSZ},
		'{id: 8'(`DEV_ID_GPIO),    useintr: 1'b1, mapsz: SLOT_MAPSZ},
		'{id: 8'(`DEV_ID_INTCTRL), useintr: 1'b0, mapsz: SLOT_MAPSZ},
		'{id: 8'd0,                useintr: 1'b0, mapsz: SLOT_MAPSZ}
	};

endpackage

// File: logic/reset_seq.sv
/*
 * Peripheral reset sequencer. periph_rst_o drops 16 edges after the last
 * reload edge (rst_p or warm_req_i). Power-off holds until rst_p.
 */
`timescale 1ns/1ns
`include "soc_defs.svh"

module reset_seq (
	 input  logic clk_2x_w
	,input  logic rst_p
	,input  logic warm_req_i
	,input  logic pwroff_req_i
	,output logic periph_rst_o
);
	import soc_pkg::*;

	rst_state_e                 state_q;
	logic [`RST_CNTR_BITSZ-1:0] cntr_q;

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			state_q <= RST_HOLD;
			cntr_q  <= '1;
		end else if (state_q != RST_OFF) begin
			if (pwroff_req_i) begin
				state_q <= RST_OFF;
			end else if (warm_req_i) begin
				// Reload on the request edge itself
				state_q <= RST_HOLD;
				cntr_q  <= '1;
			end else if (state_q == RST_HOLD) begin
				if (cntr_q != '0)
					cntr_q <= cntr_q - 1'b1;
				else
					state_q <= RST_RUN;
			end
		end
	end

	assign periph_rst_o = (state_q != RST_RUN);

	// Power-off is sticky, neither warm reset nor the counter may leave it
	a_off_sticky: assert property (@(posedge clk_2x_w)
		(state_q == RST_OFF) && !rst_p |=> (state_q == RST_OFF));

endmodule

// File: logic/apb_decoder.sv
/*
 * APB slot decoder. paddr[15:12] picks the slot; slot 3 and above go to
 * the built-in default slave, which reads zero and flags pslverr.
 */
`timescale 1ns/1ns
`include "soc_defs.svh"

module apb_decoder (
	 input  logic              clk_2x_w
	,input  logic              rst_p
	,input  soc_pkg::apb_req_t apb_req_i
	,output soc_pkg::apb_rsp_t apb_rsp_o
	,output soc_pkg::apb_req_t devtbl_req_o
	,output soc_pkg::apb_req_t gpio_req_o
	,output soc_pkg::apb_req_t intc_req_o
	,input  soc_pkg::apb_rsp_t devtbl_rsp_i
	,input  soc_pkg::apb_rsp_t gpio_rsp_i
	,input  soc_pkg::apb_rsp_t intc_rsp_i
);
	import soc_pkg::*;

	localparam int SLOT_IDX_BITSZ = `ADDR_BITSZ - `SLOT_SHIFT;

	logic [SLOT_IDX_BITSZ-1:0] slot_idx;
	slot_e                     slot;

	assign slot_idx = apb_req_i.paddr[`ADDR_BITSZ-1:`SLOT_SHIFT];

	// Anything past the last real device lands in the default slot
	assign slot = (slot_idx < SLOT_IDX_BITSZ'(SLOT_INVALID)) ?
		slot_e'(slot_idx[$bits(slot_e)-1:0]) : SLOT_INVALID;

	always_comb begin
		devtbl_req_o      = apb_req_i;
		gpio_req_o        = apb_req_i;
		intc_req_o        = apb_req_i;
		devtbl_req_o.psel = apb_req_i.psel && (slot == SLOT_DEVTBL);
		gpio_req_o.psel   = apb_req_i.psel && (slot == SLOT_GPIO);
		intc_req_o.psel   = apb_req_i.psel && (slot == SLOT_INTCTRL);
	end

	always_comb begin
		case (slot)
			SLOT_DEVTBL:  apb_rsp_o = devtbl_rsp_i;
			SLOT_GPIO:    apb_rsp_o = gpio_rsp_i;
			SLOT_INTCTRL: apb_rsp_o = intc_rsp_i;
			default: begin
				// Default slave answers at once with an error
				apb_rsp_o.prdata  = '0;
				apb_rsp_o.pready  = 1'b1;
				apb_rsp_o.pslverr = 1'b1;
			end
		endcase
	end

	a_one_slave: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		$onehot0({devtbl_req_o.psel, gpio_req_o.psel, intc_req_o.psel}));

endmodule

// File: logic/dev_table.sv
/*
 * Device table. Entry n sits at offset 8*n (id, useintr) and 8*n+4 (mapsz).
 * The reset control register is write only and reads back zero.
 */
`timescale 1ns/1ns
`include "soc_defs.svh"

module dev_table (
	 input  logic              clk_2x_w
	,input  logic              rst_p
	,input  soc_pkg::apb_req_t apb_req_i
	,output soc_pkg::apb_rsp_t apb_rsp_o
	,output logic              warm_req_o
	,output logic              pwroff_req_o
);
	import soc_pkg::*;

	localparam int ENTRY_IDX_BITSZ = $clog2(`SLOT_COUNT);
	localparam logic [`SLOT_SHIFT-1:0] TBL_END     = 8 * `SLOT_COUNT;
	localparam logic [`SLOT_SHIFT-1:0] RSTCTRL_OFS = `RSTCTRL_OFFSET;

	logic [`SLOT_SHIFT-1:0]     ofs;
	logic [ENTRY_IDX_BITSZ-1:0] entry_idx;
	dev_entry_t                 entry;
	logic                       wr_rstctrl;
	logic                       warm_q;
	logic                       pwroff_q;

	assign ofs       = apb_req_i.paddr[`SLOT_SHIFT-1:0];
	assign entry_idx = ofs[ENTRY_IDX_BITSZ+2:3];
	assign entry     = SLOT_TABLE[entry_idx];

	always_comb begin
		apb_rsp_o.prdata  = '0;
		apb_rsp_o.pready  = 1'b1;
		apb_rsp_o.pslverr = 1'b0;
		// Only word-aligned offsets inside the table return data
		if ((ofs < TBL_END) && (ofs[1:0] == 2'b00)) begin
			if (ofs[2])
				apb_rsp_o.prdata = entry.mapsz;
			else
				apb_rsp_o.prdata = data_t'({entry.useintr, entry.id});
		end
	end

	assign wr_rstctrl = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite &&
		(ofs == RSTCTRL_OFS);

	// Codes 10 and 11 both warm reset, 01 powers off
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			warm_q   <= 1'b0;
			pwroff_q <= 1'b0;
		end else begin
			warm_q   <= wr_rstctrl && apb_req_i.pwdata[1];
			pwroff_q <= wr_rstctrl && (apb_req_i.pwdata[1:0] == 2'b01);
		end
	end

	assign warm_req_o   = warm_q;
	assign pwroff_req_o = pwroff_q;

endmodule

// File: logic/gpio_port.sv
/*
 * GPIO port. Inputs go through a 2-flop synchroniser before read or
 * change detection. The change request holds until intrdy_i.
 */
`timescale 1ns/1ns
`include "soc_defs.svh"

module gpio_port (
	 input  logic              clk_2x_w
	,input  logic              rst_p
	,input  soc_pkg::apb_req_t apb_req_i
	,output soc_pkg::apb_rsp_t apb_rsp_o
	,input  soc_pkg::gpio_t    gp_i
	,output soc_pkg::gpio_t    gp_o
	,output logic              intrqst_o
	,input  logic              intrdy_i
);
	import soc_pkg::*;

	localparam logic [`SLOT_SHIFT-1:0] OFS_IN   = 'h0;
	localparam logic [`SLOT_SHIFT-1:0] OFS_OUT  = 'h4;
	localparam logic [`SLOT_SHIFT-1:0] OFS_MASK = 'h8;

	logic [`SLOT_SHIFT-1:0] ofs;
	logic                   wr_en;
	gpio_t                  sync1_q;
	gpio_t                  sync2_q;
	gpio_t                  prev_q;
	gpio_t                  out_q;
	gpio_t                  mask_q;
	gpio_t                  changed;
	logic                   intrqst_q;

	assign ofs     = apb_req_i.paddr[`SLOT_SHIFT-1:0];
	assign wr_en   = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;
	assign changed = (sync2_q ^ prev_q) & mask_q;

	always_ff @(posedge clk_2x_w) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			out_q     <= '0;
			mask_q    <= '0;
			intrqst_q <= 1'b0;
		end else begin
			if (wr_en && (ofs == OFS_OUT))
				out_q <= apb_req_i.pwdata[`GPIO_COUNT-1:0];
			if (wr_en && (ofs == OFS_MASK))
				mask_q <= apb_req_i.pwdata[`GPIO_COUNT-1:0];
			// A fresh change wins over an ack in the same cycle
			if (|changed)
				intrqst_q <= 1'b1;
			else if (intrdy_i)
				intrqst_q <= 1'b0;
		end
	end

	always_comb begin
		apb_rsp_o.pready  = 1'b1;
		apb_rsp_o.pslverr = 1'b0;
		case (ofs)
			OFS_IN:   apb_rsp_o.prdata = data_t'(sync2_q);
			OFS_OUT:  apb_rsp_o.prdata = data_t'(out_q);
			OFS_MASK: apb_rsp_o.prdata = data_t'(mask_q);
			default:  apb_rsp_o.prdata = '0;
		endcase
	end

	assign gp_o      = out_q;
	assign intrqst_o = intrqst_q;

endmodule

// File: logic/int_ctrl.sv
/*
 * Interrupt controller for one destination. Request rising edges latch
 * into pending; a claim read takes the lowest pending index, enabled or not.
 */
`timescale 1ns/1ns
`include "soc_defs.svh"

module int_ctrl (
	 input  logic              clk_2x_w
	,input  logic              rst_p
	,input  soc_pkg::apb_req_t apb_req_i
	,output soc_pkg::apb_rsp_t apb_rsp_o
	,input  soc_pkg::irq_vec_t intrqst_i
	,output soc_pkg::irq_vec_t intrdy_o
	,output logic              irq_o
);
	import soc_pkg::*;

	localparam int IDX_BITSZ = $clog2(`INT_SRC_COUNT);
	localparam logic [`SLOT_SHIFT-1:0] OFS_CLAIM  = 'h0;
	localparam logic [`SLOT_SHIFT-1:0] OFS_ENABLE = 'h4;

	logic [`SLOT_SHIFT-1:0] ofs;
	logic                   access;
	logic                   claim;
	logic                   en_wr;
	irq_vec_t               req_q;
	irq_vec_t               pend_q;
	irq_vec_t               en_q;
	irq_vec_t               ack_q;
	irq_vec_t               rise;
	irq_vec_t               claim_oh;
	irq_vec_t               claim_clr;
	logic [IDX_BITSZ-1:0]   claim_idx;
	data_t                  claim_word;
	logic                   irq_q;

	assign ofs    = apb_req_i.paddr[`SLOT_SHIFT-1:0];
	assign access = apb_req_i.psel && apb_req_i.penable;
	assign claim  = access && !apb_req_i.pwrite && (ofs == OFS_CLAIM);
	assign en_wr  = access && apb_req_i.pwrite && (ofs == OFS_ENABLE);
	assign rise   = intrqst_i & ~req_q;

	// Lowest index wins, so scan from the top down
	always_comb begin
		claim_idx = '0;
		claim_oh  = '0;
		for (int i = `INT_SRC_COUNT - 1; i >= 0; i--) begin
			if (pend_q[i]) begin
				claim_idx = IDX_BITSZ'(i);
				claim_oh  = irq_vec_t'(1) << i;
			end
		end
	end

	assign claim_clr = claim_oh & {`INT_SRC_COUNT{claim}};

	always_comb begin
		claim_word                  = '0;
		claim_word[`DATA_BITSZ-1]   = |pend_q;
		claim_word[IDX_BITSZ-1:0]   = claim_idx;
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			req_q  <= '0;
			pend_q <= '0;
			en_q   <= '0;
			ack_q  <= '0;
			irq_q  <= 1'b0;
		end else begin
			req_q  <= intrqst_i;
			pend_q <= (pend_q & ~claim_clr) | rise;
			ack_q  <= claim_clr;
			irq_q  <= |(pend_q & en_q);
			if (en_wr)
				en_q <= apb_req_i.pwdata[`INT_SRC_COUNT-1:0];
		end
	end

	always_comb begin
		apb_rsp_o.pready  = 1'b1;
		apb_rsp_o.pslverr = 1'b0;
		case (ofs)
			OFS_CLAIM:  apb_rsp_o.prdata = claim_word;
			OFS_ENABLE: apb_rsp_o.prdata = data_t'(en_q);
			default:    apb_rsp_o.prdata = '0;
		endcase
	end

	assign intrdy_o = ack_q;
	assign irq_o    = irq_q;

	// Ack names a single source and lasts one cycle, as claims are 2-cycle APB reads
	a_ack_pulse: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		(ack_q != '0) |-> $onehot(ack_q) ##1 (ack_q == '0));

endmodule

// File: logic/periph_top.sv
/*
 * APB peripheral subsystem: device table, GPIO and interrupt controller.
 * All slaves answer with zero wait states. ext_irq_i bits are edge sampled.
 */
`timescale 1ns/1ns
`include "soc_defs.svh"

module periph_top (
	 input  logic                      clk_2x_w
	,input  logic                      rst_p
	,input  soc_pkg::apb_req_t         apb_req_i
	,output soc_pkg::apb_rsp_t         apb_rsp_o
	,input  soc_pkg::gpio_t            gp_i
	,output soc_pkg::gpio_t            gp_o
	,input  logic [`INT_SRC_COUNT-2:0] ext_irq_i
	,output logic                      irq_o
	,output logic                      periph_rst_o
);
	import soc_pkg::*;

	logic     warm_req_w;
	logic     pwroff_req_w;
	logic     periph_rst_w;
	logic     gpio_intrqst_w;
	irq_vec_t intrqst_w;
	irq_vec_t intrdy_w;
	apb_req_t devtbl_req_w;
	apb_rsp_t devtbl_rsp_w;
	apb_req_t gpio_req_w;
	apb_rsp_t gpio_rsp_w;
	apb_req_t intc_req_w;
	apb_rsp_t intc_rsp_w;

	// Source order fixed by the INT_SRC_* positions
	assign intrqst_w[`INT_SRC_GPIO] = gpio_intrqst_w;
	assign intrqst_w[`INT_SRC_EXT0] = ext_irq_i[0];
	assign intrqst_w[`INT_SRC_EXT1] = ext_irq_i[1];

	assign periph_rst_o = periph_rst_w;

	reset_seq u_reset_seq (
		 .clk_2x_w     (clk_2x_w)
		,.rst_p        (rst_p)
		,.warm_req_i   (warm_req_w)
		,.pwroff_req_i (pwroff_req_w)
		,.periph_rst_o (periph_rst_w)
	);

	apb_decoder u_apb_decoder (
		 .clk_2x_w     (clk_2x_w)
		,.rst_p        (rst_p)
		,.apb_req_i    (apb_req_i)
		,.apb_rsp_o    (apb_rsp_o)
		,.devtbl_req_o (devtbl_req_w)
		,.gpio_req_o   (gpio_req_w)
		,.intc_req_o   (intc_req_w)
		,.devtbl_rsp_i (devtbl_rsp_w)
		,.gpio_rsp_i   (gpio_rsp_w)
		,.intc_rsp_i   (intc_rsp_w)
	);

	// The table stays reachable while peripherals are held in reset
	dev_table u_dev_table (
		 .clk_2x_w     (clk_2x_w)
		,.rst_p        (rst_p)
		,.apb_req_i    (devtbl_req_w)
		,.apb_rsp_o    (devtbl_rsp_w)
		,.warm_req_o   (warm_req_w)
		,.pwroff_req_o (pwroff_req_w)
	);

	gpio_port u_gpio_port (
		 .clk_2x_w  (clk_2x_w)
		,.rst_p     (periph_rst_w)
		,.apb_req_i (gpio_req_w)
		,.apb_rsp_o (gpio_rsp_w)
		,.gp_i      (gp_i)
		,.gp_o      (gp_o)
		,.intrqst_o (gpio_intrqst_w)
		,.intrdy_i  (intrdy_w[`INT_SRC_GPIO])
	);

	int_ctrl u_int_ctrl (
		 .clk_2x_w  (clk_2x_w)
		,.rst_p     (periph_rst_w)
		,.apb_req_i (intc_req_w)
		,.apb_rsp_o (intc_rsp_w)
		,.intrqst_i (intrqst_w)
		,.intrdy_o  (intrdy_w)
		,.irq_o     (irq_o)
	);

endmodule

// File: sim/tb_periph_top.sv
/*
 * Testbench for periph_top. Acts as APB master and expects zero wait states.
 * Random stimulus comes from $urandom with a fixed seed. Runs stop at a cycle limit.
 */
`timescale 1ns/1ns
`include "soc_defs.svh"

module tb_periph_top;
	import soc_pkg::*;

	localparam int CLK_HALF        = 4;
	localparam int RAND_SEED       = 32'hf36c;
	localparam int RST_HOLD_CYCLES = (1 << `RST_CNTR_BITSZ) - 1;
	// Release shows on the edge after the last hold cycle
	localparam int RELEASE_EDGES   = RST_HOLD_CYCLES + 1;
	localparam int POWER_OFF_WAIT  = 24;
	localparam int PREADY_LIMIT    = 16;
	localparam int LAST_SLOT       = (1 << (`ADDR_BITSZ - `SLOT_SHIFT)) - 1;
	// About 600 cycles of tests in total, so this leaves a wide margin
	localparam int TIMEOUT_CYCLES  = 4000;

	localparam addr_t DEVTBL_BASE     = addr_t'(SLOT_DEVTBL) << `SLOT_SHIFT;
	localparam addr_t GPIO_BASE       = addr_t'(SLOT_GPIO) << `SLOT_SHIFT;
	localparam addr_t INTC_BASE       = addr_t'(SLOT_INTCTRL) << `SLOT_SHIFT;
	localparam addr_t INVALID_BASE    = addr_t'(SLOT_INVALID) << `SLOT_SHIFT;
	localparam addr_t RSTCTRL_ADDR    = DEVTBL_BASE + addr_t'(`RSTCTRL_OFFSET);
	localparam addr_t GPIO_IN_ADDR    = GPIO_BASE + addr_t'('h0);
	localparam addr_t GPIO_OUT_ADDR   = GPIO_BASE + addr_t'('h4);
	localparam addr_t GPIO_MASK_ADDR  = GPIO_BASE + addr_t'('h8);
	localparam addr_t INTC_CLAIM_ADDR = INTC_BASE + addr_t'('h0);
	localparam addr_t INTC_EN_ADDR    = INTC_BASE + addr_t'('h4);

	logic       clk_2x_w;
	logic       rst_p;
	apb_req_t   apb_req;
	apb_rsp_t   apb_rsp;
	gpio_t      gp_i;
	gpio_t      gp_o;
	logic [1:0] ext_irq_i;
	logic       irq_o;
	logic       periph_rst_o;
	int         errors;
	int         checks;
	int         cycles;

	periph_top u_periph_top (
		 .clk_2x_w     (clk_2x_w)
		,.rst_p        (rst_p)
		,.apb_req_i    (apb_req)
		,.apb_rsp_o    (apb_rsp)
		,.gp_i         (gp_i)
		,.gp_o         (gp_o)
		,.ext_irq_i    (ext_irq_i)
		,.irq_o        (irq_o)
		,.periph_rst_o (periph_rst_o)
	);

	initial begin
		clk_2x_w = 1'b0;
		forever #CLK_HALF clk_2x_w = ~clk_2x_w;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_2x_w);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	// Table word n: even words hold id and useintr, odd words the map size
	function automatic data_t expected_table_word(input int n);
		dev_entry_t entry;
		data_t      word;
		entry = SLOT_TABLE[n / 2];
		word  = '0;
		if (n % 2 == 1) begin
			word = entry.mapsz;
		end else begin
			word[7:0] = entry.id;
			word[8]   = entry.useintr;
		end
		return word;
	endfunction

	// Claim word: valid flag in bit 31, lowest pending source index below
	function automatic data_t expected_claim(input irq_vec_t pend);
		data_t word;
		logic  found;
		word  = '0;
		found = 1'b0;
		for (int i = 0; i < `INT_SRC_COUNT; i++) begin
			if (pend[i] && !found) begin
				found = 1'b1;
				word  = data_t'(i);
				word[`DATA_BITSZ-1] = 1'b1;
			end
		end
		return word;
	endfunction

	task automatic check_value(input string name, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("FAILURE at %0t ns: %s", $time, what);
	endtask

	task automatic test_done(input string name, input int err_start);
		if (errors == err_start)
			$display("Test %s: ok", name);
		else
			$display("Test %s: %0d errors", name, errors - err_start);
	endtask

	// Setup cycle, access cycle, then completion on the following edge
	task automatic apb_transfer(input logic write, input addr_t addr, input data_t wdata,
		output data_t rdata, output logic err);
		int waits;
		@(posedge clk_2x_w);
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= write;
		apb_req.paddr   <= addr;
		apb_req.pwdata  <= wdata;
		@(posedge clk_2x_w);
		apb_req.penable <= 1'b1;
		@(negedge clk_2x_w);
		waits = 0;
		while (!apb_rsp.pready && waits < PREADY_LIMIT) begin
			@(negedge clk_2x_w);
			waits++;
		end
		if (!apb_rsp.pready)
			report_failure($sformatf("slave never raised pready for address %h", addr));
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clk_2x_w);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic apb_write(input addr_t addr, input data_t data);
		data_t rdata;
		logic  err;
		apb_transfer(1'b1, addr, data, rdata, err);
	endtask

	task automatic apb_read(input addr_t addr, output data_t data, output logic err);
		apb_transfer(1'b0, addr, '0, data, err);
	endtask

	// Counts edges from the last reload edge until periph_rst_o reads low
	task automatic wait_release(input string name);
		int edges;
		edges = 0;
		do begin
			@(posedge clk_2x_w);
			edges++;
			@(negedge clk_2x_w);
		end while (periph_rst_o && edges <= RELEASE_EDGES + 8);
		if (periph_rst_o)
			report_failure($sformatf("periph_rst_o never dropped after %s", name));
		else
			check_value({name, " release edges"}, data_t'(edges), data_t'(RELEASE_EDGES));
	endtask

	initial begin
		int          err_start;
		int          low_samples;
		int unsigned seed;
		data_t       rdata;
		logic        err;
		gpio_t       val;
		gpio_t       gpio_mask;
		gpio_t       flip;
		irq_vec_t    trig;
		irq_vec_t    en;
		irq_vec_t    pend;
		addr_t       addr;

		errors = 0;
		checks = 0;
		seed   = $urandom(RAND_SEED);
		rst_p     <= 1'b1;
		apb_req   <= '0;
		gp_i      <= '0;
		ext_irq_i <= '0;

		// Reset release
		err_start = errors;
		@(posedge clk_2x_w);
		@(negedge clk_2x_w);
		check_value("periph_rst_o in reset", data_t'(periph_rst_o), data_t'(1));
		@(posedge clk_2x_w);
		rst_p <= 1'b0;
		wait_release("external reset");
		test_done("reset release", err_start);

		// Device table and default slave
		err_start = errors;
		for (int n = 0; n < 2 * `SLOT_COUNT; n++) begin
			apb_read(DEVTBL_BASE + addr_t'(4 * n), rdata, err);
			check_value($sformatf("devtbl word %0d", n), rdata, expected_table_word(n));
			check_value("devtbl pslverr", data_t'(err), data_t'(0));
		end
		apb_read(RSTCTRL_ADDR, rdata, err);
		check_value("rstctrl readback", rdata, data_t'(0));
		apb_read(INVALID_BASE, rdata, err);
		check_value("default slave prdata", rdata, data_t'(0));
		check_value("default slave pslverr", data_t'(err), data_t'(1));
		for (int n = 0; n < 6; n++) begin
			addr = addr_t'($urandom_range(LAST_SLOT, 3) << `SLOT_SHIFT);
			addr = addr | (addr_t'($urandom) & addr_t'('hffc));
			apb_read(addr, rdata, err);
			check_value($sformatf("prdata at %h", addr), rdata, data_t'(0));
			check_value($sformatf("pslverr at %h", addr), data_t'(err), data_t'(1));
		end
		test_done("device table", err_start);

		// GPIO output and input paths
		err_start = errors;
		for (int n = 0; n < 8; n++) begin
			val = gpio_t'($urandom);
			apb_write(GPIO_OUT_ADDR, data_t'(val));
			@(negedge clk_2x_w);
			check_value("gp_o", data_t'(gp_o), data_t'(val));
			apb_read(GPIO_OUT_ADDR, rdata, err);
			check_value("gpio out readback", rdata, data_t'(val));
			check_value("gpio pslverr", data_t'(err), data_t'(0));
			val = gpio_t'($urandom);
			@(posedge clk_2x_w);
			gp_i <= val;
			repeat (3) @(posedge clk_2x_w);
			apb_read(GPIO_IN_ADDR, rdata, err);
			check_value("gpio in readback", rdata, data_t'(val));
		end
		test_done("gpio", err_start);

		// Interrupts from GPIO changes and external pins
		err_start = errors;
		for (int r = 0; r < 8; r++) begin
			trig      = irq_vec_t'($urandom);
			en        = irq_vec_t'($urandom);
			gpio_mask = gpio_t'($urandom);
			flip      = trig[`INT_SRC_GPIO] ? gpio_t'($urandom) : '0;
			apb_write(GPIO_MASK_ADDR, data_t'(gpio_mask));
			apb_write(INTC_EN_ADDR, data_t'(en));
			@(posedge clk_2x_w);
			ext_irq_i <= {trig[`INT_SRC_EXT1], trig[`INT_SRC_EXT0]};
			gp_i      <= gp_i ^ flip;
			repeat (2) @(posedge clk_2x_w);
			ext_irq_i <= '0;
			// GPIO path goes through synchroniser, detect and request stages
			repeat (6) @(posedge clk_2x_w);
			pend = trig;
			// Only pins under the change mask raise the GPIO request
			pend[`INT_SRC_GPIO] = |(flip & gpio_mask);
			@(negedge clk_2x_w);
			check_value("irq_o before claims", data_t'(irq_o), data_t'(|(pend & en)));
			while (pend != '0) begin
				apb_read(INTC_CLAIM_ADDR, rdata, err);
				check_value("claim word", rdata, expected_claim(pend));
				pend = pend & (pend - 1'b1);
			end
			repeat (2) @(posedge clk_2x_w);
			apb_read(INTC_CLAIM_ADDR, rdata, err);
			check_value("claim word when idle", rdata, data_t'(0));
			check_value("intc pslverr", data_t'(err), data_t'(0));
			@(negedge clk_2x_w);
			check_value("irq_o after claims", data_t'(irq_o), data_t'(0));
		end
		test_done("interrupts", err_start);

		// Warm reset through the reset register
		err_start = errors;
		val = gpio_t'($urandom) | gpio_t'(1);
		apb_write(GPIO_OUT_ADDR, data_t'(val));
		@(negedge clk_2x_w);
		check_value("gp_o before warm reset", data_t'(gp_o), data_t'(val));
		apb_write(RSTCTRL_ADDR, data_t'($urandom_range(3, 2)));
		@(posedge clk_2x_w);
		@(negedge clk_2x_w);
		check_value("periph_rst_o after warm write", data_t'(periph_rst_o), data_t'(1));
		wait_release("warm reset");
		check_value("gp_o after warm reset", data_t'(gp_o), data_t'(0));
		test_done("warm reset", err_start);

		// Power-off holds until the external reset, even across a warm reset write
		err_start = errors;
		low_samples = 0;
		apb_write(RSTCTRL_ADDR, data_t'(1));
		@(posedge clk_2x_w);
		repeat (POWER_OFF_WAIT) begin
			@(negedge clk_2x_w);
			if (!periph_rst_o)
				low_samples++;
		end
		apb_write(RSTCTRL_ADDR, data_t'(2));
		repeat (POWER_OFF_WAIT) begin
			@(negedge clk_2x_w);
			if (!periph_rst_o)
				low_samples++;
		end
		check_value("periph_rst_o low samples in power-off", data_t'(low_samples), data_t'(0));
		@(posedge clk_2x_w);
		rst_p <= 1'b1;
		repeat (2) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		wait_release("external reset after power-off");
		val = gpio_t'($urandom);
		apb_write(GPIO_OUT_ADDR, data_t'(val));
		apb_read(GPIO_OUT_ADDR, rdata, err);
		check_value("gpio out readback after power-off", rdata, data_t'(val));
		test_done("power-off", err_start);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: build.f
+incdir+logic
logic/soc_pkg.sv
logic/reset_seq.sv
logic/apb_decoder.sv
logic/dev_table.sv
logic/gpio_port.sv
logic/int_ctrl.sv
logic/periph_top.sv
sim/tb_periph_top.sv

// File: Makefile
VERILATOR  = verilator
TOP        = tb_periph_top
FILELIST   = build.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing -Wall
SIM_FLAGS  = --binary --timing -Wno-fatal
PASS_MSG   = SIMULATION PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
